/* bench/tb_int_div_vectors.svh */
/*
 * directed divider vectors: name, function, dividend, divisor,
 * expected remainder and quotient for a 32-bit divider
 */

`ifndef tb_int_div_vectors_svh
`define tb_int_div_vectors_svh

// columns: name, function, dividend, divisor, remainder, quotient
task automatic load_vectors();
  // --------------------------------------------------
  // unsigned, including top bit set
  // --------------------------------------------------
  add_vector("u_100_by_7", fn_u, 32'd100, 32'd7, 32'd2, 32'd14);
  add_vector("u_max_by_1", fn_u, 32'hffff_ffff, 32'd1, 32'd0, 32'hffff_ffff);
  add_vector("u_max_by_max", fn_u, 32'hffff_ffff, 32'hffff_ffff, 32'd0, 32'd1);
  add_vector("u_top_by_3", fn_u, 32'h8000_0000, 32'd3, 32'd2, 32'h2aaa_aaaa);
  add_vector("u_small_by_big", fn_u, 32'd5, 32'd10, 32'd5, 32'd0);
  add_vector("u_f0_by_16", fn_u, 32'hf000_0000, 32'h10, 32'd0, 32'h0f00_0000);
  add_vector("u_dead_by_64k", fn_u, 32'hdead_beef, 32'h1_0000, 32'h0000_beef, 32'h0000_dead);
  // same bit pattern as -7, read as unsigned
  add_vector("u_neg7_pattern", fn_u, 32'hffff_fff9, 32'd2, 32'd1, 32'h7fff_fffc);
  // --------------------------------------------------
  // signed, all four sign combinations
  // --------------------------------------------------
  add_vector("s_pos_pos", fn_s, 32'd7, 32'd2, 32'd1, 32'd3);
  add_vector("s_neg_pos", fn_s, 32'hffff_fff9, 32'd2, 32'hffff_ffff, 32'hffff_fffd);
  add_vector("s_pos_neg", fn_s, 32'd7, 32'hffff_fffe, 32'd1, 32'hffff_fffd);
  add_vector("s_neg_neg", fn_s, 32'hffff_fff9, 32'hffff_fffe, 32'hffff_ffff, 32'd3);
  add_vector("s_m100_by_7", fn_s, 32'hffff_ff9c, 32'd7, 32'hffff_fffe, 32'hffff_fff2);
  add_vector("s_min_by_2", fn_s, 32'h8000_0000, 32'd2, 32'd0, 32'hc000_0000);
  // most negative by minus one wraps back to most negative
  add_vector("s_overflow", fn_s, 32'h8000_0000, 32'hffff_ffff, 32'd0, 32'h8000_0000);
  // --------------------------------------------------
  // division by zero
  // --------------------------------------------------
  add_vector("u_by_zero", fn_u, 32'd1234, 32'd0, 32'd1234, 32'hffff_ffff);
  add_vector("u_zero_by_zero", fn_u, 32'd0, 32'd0, 32'd0, 32'hffff_ffff);
  add_vector("s_pos_by_zero", fn_s, 32'd5, 32'd0, 32'd5, 32'hffff_ffff);
  // negative dividend flips both quotient and remainder
  add_vector("s_neg_by_zero", fn_s, 32'hffff_fffb, 32'd0, 32'hffff_fffb, 32'd1);
endtask

`endif

/* bench/tb_int_div.sv */
/*
 * testbench for the iterative divider: directed table, LFSR random rows,
 * latency and back-pressure checks against a reference model
 */

module tb_int_div;

  localparam int data_width = imuldiv_pkg::default_data_width;
  localparam imuldiv_pkg::div_fn_e fn_u = imuldiv_pkg::div_fn_unsigned;
  localparam imuldiv_pkg::div_fn_e fn_s = imuldiv_pkg::div_fn_signed;
  // wait limits in clock cycles
  localparam int accept_timeout = 8;
  localparam int resp_timeout = 2 * data_width + 8;

  logic                    clk;
  logic                    reset;
  logic                    req_val;
  logic                    req_rdy;
  imuldiv_pkg::div_fn_e    req_fn;
  logic [data_width-1:0]   req_a;
  logic [data_width-1:0]   req_b;
  logic                    resp_val;
  logic                    resp_rdy;
  logic [2*data_width-1:0] resp_result;

  // directed table, filled by load_vectors
  string                 vec_name[$];
  imuldiv_pkg::div_fn_e  vec_fn[$];
  logic [31:0]           vec_a[$];
  logic [31:0]           vec_b[$];
  logic [63:0]           vec_expected[$];

  logic [31:0] lfsr_state;

  int_div_iterative #(
    .data_width (data_width)
  ) i_dut (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic add_vector(input string name, input imuldiv_pkg::div_fn_e fn,
                            input logic [31:0] a, input logic [31:0] b,
                            input logic [31:0] rem, input logic [31:0] quot);
    vec_name.push_back(name);
    vec_fn.push_back(fn);
    vec_a.push_back(a);
    vec_b.push_back(b);
    vec_expected.push_back({rem, quot});
  endtask

  `include "tb_int_div_vectors.svh"

  // --------------------------------------------------
  // failure reporting and checks
  // --------------------------------------------------

  task automatic fail_now();
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("** Error: %s expected %h actual %h", name, expected, actual);
      fail_now();
    end
  endtask

  // --------------------------------------------------
  // random numbers and reference model
  // --------------------------------------------------

  // right-shifting Galois LFSR, taps 32,30,26,25
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 32'ha300_0000;
    end
    return next;
  endfunction

  // one LFSR step per bit taken
  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return value;
  endfunction

  // magnitudes, unsigned divide, then sign fix-up
  function automatic logic [63:0] reference_result(input imuldiv_pkg::div_fn_e fn,
                                                   input logic [31:0] a,
                                                   input logic [31:0] b);
    logic        is_signed;
    logic [31:0] a_mag;
    logic [31:0] b_mag;
    logic [31:0] quot;
    logic [31:0] rem;
    is_signed = (fn == imuldiv_pkg::div_fn_signed);
    a_mag = (is_signed && a[31]) ? -a : a;
    b_mag = (is_signed && b[31]) ? -b : b;
    if (b_mag == 0) begin
      // divide by zero: all-ones quotient, dividend as remainder
      quot = 32'hffff_ffff;
      rem  = a_mag;
    end else begin
      quot = a_mag / b_mag;
      rem  = a_mag % b_mag;
    end
    if (is_signed && (a[31] ^ b[31])) begin
      quot = -quot;
    end
    if (is_signed && a[31]) begin
      rem = -rem;
    end
    return {rem, quot};
  endfunction

  // --------------------------------------------------
  // one request through the DUT
  // --------------------------------------------------

  // entered and left one time unit after a rising edge
  task automatic run_division(input string name, input imuldiv_pkg::div_fn_e fn,
                              input logic [31:0] a, input logic [31:0] b,
                              input logic [63:0] expected, input int stall);
    int          waited;
    int          edges;
    logic [63:0] held;
    req_val = 1'b1;
    req_fn  = fn;
    req_a   = a;
    req_b   = b;
    waited  = 0;
    while (!req_rdy) begin
      if (waited >= accept_timeout) begin
        $display("%s: the divider never raised req_rdy for the request", name);
        fail_now();
      end
      @(posedge clk);
      #1;
      waited++;
    end
    // accepting edge, counted as the first one
    @(posedge clk);
    #1;
    req_val = 1'b0;
    // request inputs change after accept, the result must not follow them
    req_fn  = (fn == fn_u) ? fn_s : fn_u;
    req_a   = ~a;
    req_b   = ~b;
    edges   = 1;
    // st_calc: wait for the response, no new request may be taken
    while (!resp_val) begin
      check_value({name, " req_rdy while busy"}, 64'd0, req_rdy);
      if (edges >= resp_timeout) begin
        $display("%s: resp_val did not rise after the request was taken", name);
        fail_now();
      end
      @(posedge clk);
      #1;
      edges++;
    end
    check_value({name, " latency"}, data_width + 1, edges);
    held = resp_result;
    check_value(name, expected, held);
    // st_done under back-pressure, with a competing request waiting
    req_val = 1'b1;
    for (int i = 0; i < stall; i++) begin
      @(posedge clk);
      #1;
      check_value({name, " resp_val held"}, 64'd1, resp_val);
      check_value({name, " result held"}, held, resp_result);
      check_value({name, " req_rdy held low"}, 64'd0, req_rdy);
    end
    req_val  = 1'b0;
    resp_rdy = 1'b1;
    check_value({name, " req_rdy at handover"}, 64'd0, req_rdy);
    @(posedge clk);
    #1;
    resp_rdy = 1'b0;
    check_value({name, " resp_val after handover"}, 64'd0, resp_val);
    check_value({name, " req_rdy after handover"}, 64'd1, req_rdy);
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------

  initial begin
    logic [31:0]          a;
    logic [31:0]          b;
    imuldiv_pkg::div_fn_e fn;
    reset      = 1'b1;
    req_val    = 1'b0;
    req_fn     = fn_u;
    req_a      = '0;
    req_b      = '0;
    resp_rdy   = 1'b0;
    lfsr_state = 32'h29ed_3b97;
    load_vectors();
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    // idle after reset
    check_value("reset req_rdy", 64'd1, req_rdy);
    check_value("reset resp_val", 64'd0, resp_val);
    for (int i = 0; i < vec_name.size(); i++) begin
      run_division(vec_name[i], vec_fn[i], vec_a[i], vec_b[i], vec_expected[i],
                   random_bits(3));
    end
    for (int i = 0; i < 64; i++) begin
      fn = imuldiv_pkg::div_fn_e'(random_bits(1));
      a  = random_bits(32);
      b  = random_bits(32);
      // spread divisor sizes, with an occasional zero
      b  = b >> random_bits(5);
      if (random_bits(3) == 0) begin
        b = '0;
      end
      run_division($sformatf("random_%0d", i), fn, a, b, reference_result(fn, a, b),
                   random_bits(3));
    end
    $display("All tests passed");
    $finish;
  end

endmodule

/* compile.f */
+incdir+bench
rtl/imuldiv_pkg.sv
rtl/div_ctrl_if.sv
rtl/int_div_dpath.sv
rtl/int_div_ctrl.sv
rtl/int_div_iterative.sv
bench/tb_int_div.sv

/* rtl/div_ctrl_if.sv */
/*
 * control and status bundle between divider control unit and datapath
 */

interface div_ctrl_if;

  // enables and mux selects from the control unit
  logic a_en;
  logic b_en;
  logic a_mux_sel;
  logic sub_mux_sel;
  logic cntr_mux_sel;
  logic sign_en;

  // status back from the datapath
  logic sub_neg;
  logic counter_is_zero;

  modport ctrl (
    output a_en, b_en, a_mux_sel, sub_mux_sel, cntr_mux_sel, sign_en,
    input  sub_neg, counter_is_zero
  );

  modport dpath (
    input  a_en, b_en, a_mux_sel, sub_mux_sel, cntr_mux_sel, sign_en,
    output sub_neg, counter_is_zero
  );

endinterface

/* rtl/imuldiv_pkg.sv */
/*
 * shared definitions for the iterative integer divider
 * function encoding, control states and default operand width
 */

package imuldiv_pkg;

  // --------------------------------------------------
  // operand width
  // --------------------------------------------------

  // width of dividend, divisor, quotient and remainder
  parameter int default_data_width = 32;

  // --------------------------------------------------
  // request function
  // --------------------------------------------------

  // one bit picks the operand interpretation
  // unsigned: operands are plain magnitudes
  // signed: operands are two's complement, the result is sign-corrected
  typedef enum logic [0:0] {
    div_fn_unsigned = 1'b0,
    div_fn_signed   = 1'b1
  } div_fn_e;

  // --------------------------------------------------
  // control unit states
  // --------------------------------------------------

  // st_idle: waiting for a request, req_rdy high
  // st_calc: one shift-subtract step per cycle
  // st_done: result held until the receiver takes it
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } div_state_e;

endpackage

/* rtl/int_div_ctrl.sv */
/*
 * divider control unit: sequences accept, iterate and respond
 * and drives the datapath enables and mux selects
 */

module int_div_ctrl (
  input  logic      clk,
  input  logic      reset,
  input  logic      req_val,
  output logic      req_rdy,
  output logic      resp_val,
  input  logic      resp_rdy,
  div_ctrl_if.ctrl  ctl
);

  imuldiv_pkg::div_state_e state;
  imuldiv_pkg::div_state_e state_next;

  logic req_go;
  logic resp_go;

  // handshakes complete on edges where both sides are high
  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // --------------------------------------------------
  // state register
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_pkg::st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      imuldiv_pkg::st_idle: begin
        if (req_go) begin
          state_next = imuldiv_pkg::st_calc;
        end
      end
      imuldiv_pkg::st_calc: begin
        // the step at count zero is the last one
        if (ctl.counter_is_zero) begin
          state_next = imuldiv_pkg::st_done;
        end
      end
      imuldiv_pkg::st_done: begin
        // hold the result until the receiver takes it
        if (resp_go) begin
          state_next = imuldiv_pkg::st_idle;
        end
      end
      default: begin
        state_next = imuldiv_pkg::st_idle;
      end
    endcase
  end

  // --------------------------------------------------
  // control outputs
  // --------------------------------------------------

  always_comb begin
    req_rdy          = 1'b0;
    resp_val         = 1'b0;
    ctl.a_en         = 1'b0;
    ctl.b_en         = 1'b0;
    ctl.a_mux_sel    = 1'b0;
    ctl.cntr_mux_sel = 1'b0;
    ctl.sign_en      = 1'b0;
    // a negative trial difference means restore
    ctl.sub_mux_sel  = ctl.sub_neg;
    case (state)
      imuldiv_pkg::st_idle: begin
        req_rdy     = 1'b1;
        // load operands, signs and counter preset on accept
        ctl.a_en    = req_go;
        ctl.b_en    = req_go;
        ctl.sign_en = req_go;
      end
      imuldiv_pkg::st_calc: begin
        // step the working register and count down
        ctl.a_en         = 1'b1;
        ctl.a_mux_sel    = 1'b1;
        ctl.cntr_mux_sel = 1'b1;
      end
      imuldiv_pkg::st_done: begin
        resp_val = 1'b1;
      end
      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

endmodule

/* rtl/int_div_dpath.sv */
/*
 * divider datapath: operand magnitudes, restoring shift-subtract step,
 * iteration counter and sign fix-up of quotient and remainder
 */

module int_div_dpath #(
  parameter int data_width = imuldiv_pkg::default_data_width
) (
  input  logic                      clk,
  input  logic                      reset,
  input  imuldiv_pkg::div_fn_e      req_fn,
  input  logic [data_width-1:0]     req_a,
  input  logic [data_width-1:0]     req_b,
  div_ctrl_if.dpath                 ctl,
  output logic [2*data_width-1:0]   resp_result
);

  // one counter value per dividend bit
  localparam int cntr_width = $clog2(data_width);
  // top bit of the working register, holds the sign of the trial subtraction
  localparam int msb = 2 * data_width;

  // --------------------------------------------------
  // operand magnitudes
  // --------------------------------------------------

  logic                  req_signed;
  logic [data_width-1:0] a_mag;
  logic [data_width-1:0] b_mag;

  assign req_signed = (req_fn == imuldiv_pkg::div_fn_signed);

  // negative signed operands are flipped to their magnitude
  assign a_mag = (req_signed && req_a[data_width-1]) ? -req_a : req_a;
  assign b_mag = (req_signed && req_b[data_width-1]) ? -req_b : req_b;

  // --------------------------------------------------
  // registers
  // --------------------------------------------------

  // remainder in the upper half, quotient bits shift in at the bottom
  logic [msb:0] a_reg;
  // divisor aligned with the remainder half
  logic [msb:0] b_reg;

  logic [cntr_width-1:0] counter_reg;

  // function and operand signs of the division in flight
  imuldiv_pkg::div_fn_e fn_reg;
  logic                 a_sign_reg;
  logic                 b_sign_reg;

  // --------------------------------------------------
  // shift-subtract step
  // --------------------------------------------------

  logic [msb:0] a_initial;
  logic [msb:0] b_initial;
  logic [msb:0] a_shift;
  logic [msb:0] sub_out;
  logic [msb:0] sub_keep;
  logic [msb:0] sub_restore;
  logic [msb:0] sub_mux_out;
  logic [msb:0] a_mux_out;

  assign a_initial = {{(data_width + 1){1'b0}}, a_mag};
  assign b_initial = {1'b0, b_mag, {data_width{1'b0}}};

  // bring the next dividend bit into the remainder half
  assign a_shift = {a_reg[msb-1:0], 1'b0};
  assign sub_out = a_shift - b_reg;

  // divisor fitted: keep the difference, quotient bit one
  assign sub_keep    = {sub_out[msb:1], 1'b1};
  // divisor too large: keep the shifted value, quotient bit zero
  assign sub_restore = {a_shift[msb:1], 1'b0};

  assign sub_mux_out = ctl.sub_mux_sel ? sub_restore : sub_keep;
  assign a_mux_out   = ctl.a_mux_sel ? sub_mux_out : a_initial;

  assign ctl.sub_neg = sub_out[msb];

  // --------------------------------------------------
  // iteration counter
  // --------------------------------------------------

  logic [cntr_width-1:0] counter_next;

  // preset to the last bit index, then count down to zero
  assign counter_next = ctl.cntr_mux_sel ? (counter_reg - 1'b1)
                                         : cntr_width'(data_width - 1);

  assign ctl.counter_is_zero = (counter_reg == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      counter_reg <= '0;
      fn_reg      <= imuldiv_pkg::div_fn_unsigned;
      a_sign_reg  <= 1'b0;
      b_sign_reg  <= 1'b0;
    end else begin
      // counter moves together with the working register
      if (ctl.a_en) begin
        counter_reg <= counter_next;
      end
      if (ctl.sign_en) begin
        fn_reg     <= req_fn;
        a_sign_reg <= req_a[data_width-1];
        b_sign_reg <= req_b[data_width-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ctl.a_en) begin
      a_reg <= a_mux_out;
    end
    if (ctl.b_en) begin
      b_reg <= b_initial;
    end
  end

  // --------------------------------------------------
  // sign fix-up
  // --------------------------------------------------

  logic                  fn_signed;
  logic                  quot_neg;
  logic                  rem_neg;
  logic [data_width-1:0] quot_mag;
  logic [data_width-1:0] rem_mag;
  logic [data_width-1:0] quot_out;
  logic [data_width-1:0] rem_out;

  assign quot_mag = a_reg[data_width-1:0];
  assign rem_mag  = a_reg[msb-1:data_width];

  assign fn_signed = (fn_reg == imuldiv_pkg::div_fn_signed);
  // quotient sign from the sign difference, remainder sign from the dividend
  assign quot_neg  = fn_signed && (a_sign_reg ^ b_sign_reg);
  assign rem_neg   = fn_signed && a_sign_reg;

  assign quot_out = quot_neg ? -quot_mag : quot_mag;
  assign rem_out  = rem_neg ? -rem_mag : rem_mag;

  assign resp_result = {rem_out, quot_out};

endmodule

/* rtl/int_div_iterative.sv */
/*
 * iterative restoring integer divider, signed or unsigned,
 * val/rdy request and response with {remainder, quotient} result
 */

module int_div_iterative #(
  parameter int data_width = imuldiv_pkg::default_data_width
) (
  input  logic                      clk,
  input  logic                      reset,

  // request side
  input  logic                      req_val,
  output logic                      req_rdy,
  input  imuldiv_pkg::div_fn_e      req_fn,
  input  logic [data_width-1:0]     req_a,
  input  logic [data_width-1:0]     req_b,

  // response side
  output logic                      resp_val,
  input  logic                      resp_rdy,
  output logic [2*data_width-1:0]   resp_result
);

  // --------------------------------------------------
  // control unit to datapath bundle
  // --------------------------------------------------

  div_ctrl_if ctl_if ();

  // state machine, owns both handshakes
  int_div_ctrl i_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .ctl      (ctl_if.ctrl)
  );

  // --------------------------------------------------
  // datapath
  // --------------------------------------------------

  // operands are sampled straight from the request ports on accept
  int_div_dpath #(
    .data_width (data_width)
  ) i_dpath (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .ctl         (ctl_if.dpath),
    .resp_result (resp_result)
  );

endmodule
